// File: alu_other_unit.f
logic/rvv_isa_pkg.sv
logic/alu_uop_pkg.sv
logic/other_op_decode.sv
logic/operand_prep.sv
logic/elem_extend.sv
logic/vmerge_lane.sv
logic/result_stage.sv
logic/alu_other_unit.sv
sim/alu_other_checker.sv
sim/tb_alu_other_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f alu_other_unit.f --top-module tb_alu_other_unit \
  -Mdir obj_dir -o sim_alu_other > build.log 2>&1 \
  && ./obj_dir/sim_alu_other > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }

grep -q "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/tb_alu_other_unit.sv
`timescale 1ns/1ns

module tb_alu_other_unit
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        uop_valid;
  alu_uop_t    uop;
  rob_result_t result;
  int          checks;
  int          data_errors;
  int          valid_errors;
  int          timeouts;
  logic [31:0] lfsr;

  alu_other_unit u_alu_other_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .uop_valid (uop_valid),
    .uop       (uop),
    .result    (result)
  );

  alu_other_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result       (result),
    .checks       (checks),
    .data_errors  (data_errors),
    .valid_errors (valid_errors)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [VLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  // random fields, every operand marked valid
  task automatic random_uop(output alu_uop_t u);
    logic [VLEN-1:0] r;
    u = '0;
    take_bits(3, r);
    u.rob_entry = r[2:0];
    take_bits(3, r);
    u.uop_index = r[2:0];
    take_bits(VLEN, r);
    u.v0_data = r;
    take_bits(VLEN, r);
    u.vs1_data = r;
    take_bits(VLEN, r);
    u.vs2_data = r;
    take_bits(XLEN, r);
    u.rs1_data = r[XLEN-1:0];
    take_bits(5, r);
    u.vs1            = r[4:0];
    u.v0_data_valid  = 1'b1;
    u.vs1_data_valid = 1'b1;
    u.vs2_data_valid = 1'b1;
    u.rs1_data_valid = 1'b1;
  endtask

  // drive one uop and wait until its result has been compared
  task automatic send_checked(input alu_uop_t u);
    int n;
    int t;
    @(negedge clk);
    uop       = u;
    uop_valid = 1'b1;
    @(posedge clk);
    n = checks;
    t = 0;
    while (checks <= n && t < 8) begin
      @(posedge clk);
      t++;
    end
    if (checks <= n) begin
      $display("no result compared within 8 cycles of a uop");
      timeouts++;
    end
  endtask

  task automatic run_directed();
    alu_uop_t u;
    logic [4:0] ext_ops [4];
    ext_ops = '{VZEXT_VF2, VSEXT_VF2, VZEXT_VF4, VSEXT_VF4};
    for (int e = 0; e < 4; e++) begin
      for (int f = 0; f < 3; f++) begin
        random_uop(u);
        u.funct6  = VMERGE_VMV;
        u.funct3  = (f == 0) ? OPIVV : (f == 1) ? OPIVX : OPIVI;
        u.vd_eew  = eew_e'(e);
        u.vs2_eew = eew_e'(e);
        u.vm      = 1'b1;
        send_checked(u);
        random_uop(u);
        u.funct6  = VMERGE_VMV;
        u.funct3  = (f == 0) ? OPIVV : (f == 1) ? OPIVX : OPIVI;
        u.vs2_eew = eew_e'(e);
        send_checked(u);
      end
      for (int k = 0; k < 4; k++) begin
        random_uop(u);
        u.funct3         = OPMVV;
        u.funct6         = VXUNARY0;
        u.vs1            = ext_ops[k];
        u.vs2_eew        = eew_e'(e);
        u.vs1_data_valid = 1'b0;
        send_checked(u);
      end
      random_uop(u);
      u.funct3  = OPMVV;
      u.funct6  = VWXUNARY0;
      u.vs1     = VMV_X_S;
      u.vm      = 1'b1;
      u.vs2_eew = eew_e'(e);
      send_checked(u);
      random_uop(u);
      u.funct3 = OPMVX;
      u.funct6 = VWXUNARY0;
      u.vm     = 1'b1;
      u.vd_eew = eew_e'(e);
      send_checked(u);
      random_uop(u);
      u.funct3 = OPIVI;
      u.funct6 = VSMUL_VMVNRR;
      u.vm     = 1'b1;
      send_checked(u);
    end
  endtask

  // back to back uops with random opcodes and valids
  task automatic run_random(input int count);
    alu_uop_t        u;
    logic [VLEN-1:0] r;
    int              n;
    int              t;
    for (int i = 0; i < count; i++) begin
      random_uop(u);
      take_bits(16, r);
      u.funct3  = funct3_e'(r[2:0]);
      u.funct6  = r[4:3] == 2'd0 ? VMERGE_VMV : r[4:3] == 2'd1 ? VXUNARY0 :
                  r[4:3] == 2'd2 ? VWXUNARY0 : (r[5] ? VSMUL_VMVNRR : r[11:6]);
      u.vm      = r[12];
      u.vd_eew  = eew_e'(r[14:13]);
      u.vs2_eew = eew_e'({1'b0, r[15]});
      take_bits(5, r);
      u.v0_data_valid  = r[0] | r[4];
      u.vs1_data_valid = r[1];
      u.vs2_data_valid = r[2] | r[4];
      u.rs1_data_valid = r[3] | r[4];
      take_bits(3, r);
      @(negedge clk);
      uop       = u;
      uop_valid = |r[2:0];
    end
    @(posedge clk);
    n = checks;
    t = 0;
    while (checks <= n + 1 && t < 8) begin
      @(posedge clk);
      t++;
    end
    if (checks <= n + 1) begin
      $display("random burst did not drain within 8 cycles");
      timeouts++;
    end
  endtask

  initial begin
    alu_uop_t u;
    int       t;
    clk      = 1'b0;
    arst_n   = 1'b0;
    timeouts = 0;
    lfsr     = 32'he3b803c1;
    // legal uop held while reset is asserted
    random_uop(u);
    u.funct6  = VMERGE_VMV;
    u.funct3  = OPIVV;
    u.vm      = 1'b1;
    uop       = u;
    uop_valid = 1'b1;
    t         = 0;
    while (t < 10) begin
      @(posedge clk);
      t++;
    end
    @(negedge clk);
    arst_n    = 1'b1;
    uop_valid = 1'b0;
    run_directed();
    run_random(300);
    $display("checks=%0d data_errors=%0d valid_errors=%0d timeouts=%0d",
             checks, data_errors, valid_errors, timeouts);
    if (data_errors == 0 && valid_errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sim/alu_other_checker.sv
`timescale 1ns/1ns

module alu_other_checker
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  input  rob_result_t result,
  output int          checks,
  output int          data_errors,
  output int          valid_errors
);

  // one-deep model of the uop taken at the last rising edge
  logic                       pend;
  logic                       exp_valid;
  logic [VLEN-1:0]            exp_data;
  logic [ROB_DEPTH_WIDTH-1:0] exp_rob;
  string                      exp_name;

  function automatic logic [VLEN-1:0] splat(logic [XLEN-1:0] x, eew_e eew);
    logic [VLEN-1:0] r;
    r = '0;
    for (int b = 0; b < VLEN; b++) begin
      if (int'(eew) < 3) begin
        r[b] = x[b % (8 << int'(eew))];
      end
    end
    return r;
  endfunction

  function automatic logic [VLEN-1:0] first_elem(logic [VLEN-1:0] x, eew_e eew);
    logic [VLEN-1:0] r;
    r = '0;
    for (int b = 0; b < VLEN; b++) begin
      if (int'(eew) < 3 && b < (8 << int'(eew))) begin
        r[b] = x[b];
      end
    end
    return r;
  endfunction

  function automatic logic [VLEN-1:0] merge_ref(logic [VLEN-1:0] a, logic [VLEN-1:0] s,
                                               logic [VLEN-1:0] v0, int idx, eew_e eew);
    logic [VLEN-1:0] r;
    int              ew;
    int              n;
    r = '0;
    if (int'(eew) < 3) begin
      ew = 8 << int'(eew);
      n  = VLEN / ew;
      for (int b = 0; b < VLEN; b++) begin
        r[b] = v0[idx * n + b / ew] ? a[b] : s[b];
      end
    end
    return r;
  endfunction

  // narrow elements of the chosen slice widened f times
  function automatic logic [VLEN-1:0] extend_ref(logic [VLEN-1:0] v, eew_e eew, int f,
                                                int idx, logic sgn);
    logic [VLEN-1:0] r;
    int              sw;
    int              dw;
    int              base;
    int              j;
    int              k;
    r = '0;
    if (eew == EEW8 || (f == 2 && eew == EEW16)) begin
      sw   = 8 << int'(eew);
      dw   = sw * f;
      base = (f == 2) ? (idx % 2) * (VLEN / 2) : (idx % 4) * (VLEN / 4);
      for (int b = 0; b < VLEN; b++) begin
        j    = b / dw;
        k    = b % dw;
        r[b] = (k < sw) ? v[base + j * sw + k] : (sgn & v[base + j * sw + sw - 1]);
      end
    end
    return r;
  endfunction

  task automatic predict();
    logic ok;
    logic is_int;
    logic [VLEN-1:0] a;
    ok       = 1'b0;
    exp_data = '0;
    exp_name = "illegal";
    is_int   = (uop.funct3 == OPIVV || uop.funct3 == OPIVX || uop.funct3 == OPIVI);
    if (is_int && uop.funct6 == VMERGE_VMV) begin
      a  = (uop.funct3 == OPIVV) ? uop.vs1_data
                                 : splat(uop.rs1_data, uop.vm ? uop.vd_eew : uop.vs2_eew);
      ok = ((uop.funct3 == OPIVV) ? uop.vs1_data_valid : uop.rs1_data_valid) &&
           (uop.vm || (uop.vs2_data_valid && uop.v0_data_valid));
      exp_name = uop.vm ? "vmv.v" : "vmerge";
      exp_data = uop.vm ? a : merge_ref(a, uop.vs2_data, uop.v0_data,
                                        int'(uop.uop_index), uop.vs2_eew);
    end else if (uop.funct3 == OPIVI && uop.funct6 == VSMUL_VMVNRR) begin
      exp_name = "vmvnr";
      ok       = uop.vm && uop.vs2_data_valid;
      exp_data = uop.vs2_data;
    end else if (uop.funct3 == OPMVV && uop.funct6 == VXUNARY0 &&
                 (uop.vs1 == VZEXT_VF2 || uop.vs1 == VSEXT_VF2 ||
                  uop.vs1 == VZEXT_VF4 || uop.vs1 == VSEXT_VF4)) begin
      exp_name = (uop.vs1 == VZEXT_VF2 || uop.vs1 == VSEXT_VF2) ? "vext.vf2" : "vext.vf4";
      ok       = !uop.vs1_data_valid && uop.vs2_data_valid &&
                 ((exp_name == "vext.vf2") ? (uop.vs2_eew == EEW8 || uop.vs2_eew == EEW16)
                                           : (uop.vs2_eew == EEW8));
      exp_data = extend_ref(uop.vs2_data, uop.vs2_eew, (exp_name == "vext.vf2") ? 2 : 4,
                            int'(uop.uop_index), uop.vs1[0]);
    end else if (uop.funct3 == OPMVV && uop.funct6 == VWXUNARY0 && uop.vs1 == VMV_X_S) begin
      exp_name = "vmv.x.s";
      ok       = uop.vm && uop.vs2_data_valid;
      exp_data = first_elem(uop.vs2_data, uop.vs2_eew);
    end else if (uop.funct3 == OPMVX && uop.funct6 == VWXUNARY0) begin
      exp_name = "vmv.s.x";
      ok       = uop.vm && uop.rs1_data_valid;
      exp_data = first_elem(VLEN'(uop.rs1_data), uop.vd_eew);
    end
    exp_valid = ok && uop_valid;
    exp_rob   = uop.rob_entry;
  endtask

  initial begin
    pend         = 1'b0;
    checks       = 0;
    data_errors  = 0;
    valid_errors = 0;
  end

  always @(posedge clk) begin
    if (!arst_n) begin
      pend = 1'b0;
    end else begin
      predict();
      pend = 1'b1;
    end
  end

  // compare at the falling edge where the result is settled
  always @(negedge clk) begin
    if (!pend) begin
      if (result !== '0) begin
        $display("result not cleared while reset is held");
        valid_errors++;
      end
    end else begin
      checks++;
      if (result.w_valid !== exp_valid) begin
        $display("FAIL %s w_valid expected %b actual %b", exp_name, exp_valid,
                 result.w_valid);
        valid_errors++;
      end
      if (result.rob_entry !== exp_rob) begin
        $display("FAIL %s rob_entry expected %h actual %h", exp_name, exp_rob,
                 result.rob_entry);
        data_errors++;
      end
      if (exp_valid && result.w_data !== exp_data) begin
        $display("FAIL %s w_data expected %h actual %h", exp_name, exp_data,
                 result.w_data);
        data_errors++;
      end
    end
  end

endmodule

// File: logic/alu_other_unit.sv
`timescale 1ns/1ns

module alu_other_unit
  import alu_uop_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output rob_result_t result
);

  op_class_e       op_class;
  logic            op_ok;
  logic            ext_signed;
  logic [VLEN-1:0] src1;
  logic [VLEN-1:0] src2;
  logic [VLEN-1:0] ext_data;
  logic [VLEN-1:0] merge_data;

  other_op_decode u_other_op_decode (
    .uop        (uop),
    .uop_valid  (uop_valid),
    .op_class   (op_class),
    .ext_signed (ext_signed),
    .op_ok      (op_ok)
  );

  operand_prep u_operand_prep (
    .uop      (uop),
    .op_class (op_class),
    .src1     (src1),
    .src2     (src2)
  );

  elem_extend u_elem_extend (
    .src2       (src2),
    .vs2_eew    (uop.vs2_eew),
    .op_class   (op_class),
    .ext_signed (ext_signed),
    .ext_data   (ext_data)
  );

  vmerge_lane u_vmerge_lane (
    .src1       (src1),
    .src2       (src2),
    .v0_data    (uop.v0_data),
    .uop_index  (uop.uop_index),
    .vs2_eew    (uop.vs2_eew),
    .merge_data (merge_data)
  );

  result_stage u_result_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .op_class   (op_class),
    .op_ok      (op_ok),
    .rob_entry  (uop.rob_entry),
    .src1       (src1),
    .src2       (src2),
    .ext_data   (ext_data),
    .merge_data (merge_data),
    .result     (result)
  );

endmodule

// File: logic/result_stage.sv
`timescale 1ns/1ns

module result_stage
  import alu_uop_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  op_class_e                  op_class,
  input  logic                       op_ok,
  input  logic [ROB_DEPTH_WIDTH-1:0] rob_entry,
  input  logic [VLEN-1:0]            src1,
  input  logic [VLEN-1:0]            src2,
  input  logic [VLEN-1:0]            ext_data,
  input  logic [VLEN-1:0]            merge_data,
  output rob_result_t                result
);

  logic [VLEN-1:0] sel_data;

  always_comb begin
    case (op_class)
      OP_MV_V, OP_MV_S_X:     sel_data = src1;
      OP_MERGE:               sel_data = merge_data;
      OP_MV_NRR, OP_MV_X_S:   sel_data = src2;
      OP_EXT_VF2, OP_EXT_VF4: sel_data = ext_data;
      default:                sel_data = '0;
    endcase
  end

  // single register stage toward the ROB
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result.rob_entry <= rob_entry;
      result.w_data    <= sel_data;
      result.w_valid   <= op_ok;
    end
  end

  // a valid write-back needs a selected source
  a_ok_has_class: assert property (@(posedge clk) disable iff (!arst_n)
    op_ok |-> op_class != OP_NONE)
    else $error("operands accepted for an unsupported opcode");

endmodule

// File: logic/vmerge_lane.sv
`timescale 1ns/1ns

module vmerge_lane
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
(
  input  logic [VLEN-1:0]            src1,
  input  logic [VLEN-1:0]            src2,
  input  logic [VLEN-1:0]            v0_data,
  input  logic [UOP_INDEX_WIDTH-1:0] uop_index,
  input  eew_e                       vs2_eew,
  output logic [VLEN-1:0]            merge_data
);

  // one mask bit per element of this uop
  logic [VLENB-1:0] mask;

  always_comb begin
    case (vs2_eew)
      EEW8:    mask = v0_data[uop_index * VLENB +: VLENB];
      EEW16:   mask = {{(VLENB/2){1'b0}}, v0_data[uop_index * (VLENB/2) +: VLENB/2]};
      EEW32:   mask = {{(VLENB*3/4){1'b0}}, v0_data[uop_index * (VLENB/4) +: VLENB/4]};
      default: mask = '0;
    endcase
  end

  always_comb begin
    merge_data = '0;
    case (vs2_eew)
      EEW8: begin
        for (int i = 0; i < VLEN/BYTE_WIDTH; i++) begin
          merge_data[i*BYTE_WIDTH +: BYTE_WIDTH] = mask[i] ? src1[i*BYTE_WIDTH +: BYTE_WIDTH]
                                                           : src2[i*BYTE_WIDTH +: BYTE_WIDTH];
        end
      end
      EEW16: begin
        for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
          merge_data[i*HWORD_WIDTH +: HWORD_WIDTH] =
            mask[i] ? src1[i*HWORD_WIDTH +: HWORD_WIDTH] : src2[i*HWORD_WIDTH +: HWORD_WIDTH];
        end
      end
      EEW32: begin
        for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
          merge_data[i*WORD_WIDTH +: WORD_WIDTH] =
            mask[i] ? src1[i*WORD_WIDTH +: WORD_WIDTH] : src2[i*WORD_WIDTH +: WORD_WIDTH];
        end
      end
      default: merge_data = '0;
    endcase
  end

endmodule

// File: logic/elem_extend.sv
`timescale 1ns/1ns

module elem_extend
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
(
  input  logic [VLEN-1:0] src2,
  input  eew_e            vs2_eew,
  input  op_class_e       op_class,
  input  logic            ext_signed,
  output logic [VLEN-1:0] ext_data
);

  always_comb begin
    ext_data = '0;
    if (op_class == OP_EXT_VF2 && vs2_eew == EEW8) begin
      // byte to halfword
      for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
        ext_data[i*HWORD_WIDTH +: HWORD_WIDTH] =
          {{BYTE_WIDTH{ext_signed & src2[i*BYTE_WIDTH + BYTE_WIDTH-1]}},
           src2[i*BYTE_WIDTH +: BYTE_WIDTH]};
      end
    end else if (op_class == OP_EXT_VF2 && vs2_eew == EEW16) begin
      // halfword to word
      for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
        ext_data[i*WORD_WIDTH +: WORD_WIDTH] =
          {{HWORD_WIDTH{ext_signed & src2[i*HWORD_WIDTH + HWORD_WIDTH-1]}},
           src2[i*HWORD_WIDTH +: HWORD_WIDTH]};
      end
    end else if (op_class == OP_EXT_VF4 && vs2_eew == EEW8) begin
      // byte to word
      for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
        ext_data[i*WORD_WIDTH +: WORD_WIDTH] =
          {{(WORD_WIDTH-BYTE_WIDTH){ext_signed & src2[i*BYTE_WIDTH + BYTE_WIDTH-1]}},
           src2[i*BYTE_WIDTH +: BYTE_WIDTH]};
      end
    end
  end

endmodule

// File: logic/operand_prep.sv
`timescale 1ns/1ns

module operand_prep
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
(
  input  alu_uop_t        uop,
  input  op_class_e       op_class,
  output logic [VLEN-1:0] src1,
  output logic [VLEN-1:0] src2
);

  // scalar copied into every element of the register
  function automatic logic [VLEN-1:0] repeat_scalar(logic [XLEN-1:0] x, eew_e eew);
    case (eew)
      EEW8:    repeat_scalar = {(VLEN/BYTE_WIDTH){x[BYTE_WIDTH-1:0]}};
      EEW16:   repeat_scalar = {(VLEN/HWORD_WIDTH){x[HWORD_WIDTH-1:0]}};
      EEW32:   repeat_scalar = {(VLEN/WORD_WIDTH){x[WORD_WIDTH-1:0]}};
      default: repeat_scalar = '0;
    endcase
  endfunction

  // element 0 only, upper elements zero
  function automatic logic [VLEN-1:0] keep_elem0(logic [VLEN-1:0] x, eew_e eew);
    case (eew)
      EEW8:    keep_elem0 = {{(VLEN-BYTE_WIDTH){1'b0}}, x[BYTE_WIDTH-1:0]};
      EEW16:   keep_elem0 = {{(VLEN-HWORD_WIDTH){1'b0}}, x[HWORD_WIDTH-1:0]};
      EEW32:   keep_elem0 = {{(VLEN-WORD_WIDTH){1'b0}}, x[WORD_WIDTH-1:0]};
      default: keep_elem0 = '0;
    endcase
  endfunction

  logic [VLEN/2-1:0] vs2_half;
  logic [VLEN/4-1:0] vs2_quarter;

  // slice of vs2 feeding this uop of an extension
  assign vs2_half    = uop.uop_index[0] ? uop.vs2_data[VLEN/2 +: VLEN/2]
                                        : uop.vs2_data[0 +: VLEN/2];
  assign vs2_quarter = uop.vs2_data[uop.uop_index[1:0] * (VLEN/4) +: VLEN/4];

  always_comb begin
    src1 = '0;
    src2 = '0;
    case (op_class)
      OP_MV_V: begin
        src1 = (uop.funct3 == OPIVV) ? uop.vs1_data
                                     : repeat_scalar(uop.rs1_data, uop.vd_eew);
      end
      // vmerge splats at the source width
      OP_MERGE: begin
        src1 = (uop.funct3 == OPIVV) ? uop.vs1_data
                                     : repeat_scalar(uop.rs1_data, uop.vs2_eew);
        src2 = uop.vs2_data;
      end
      OP_MV_NRR: begin
        src2 = uop.vs2_data;
      end
      OP_EXT_VF2: begin
        src2 = {2{vs2_half}};
      end
      OP_EXT_VF4: begin
        src2 = {4{vs2_quarter}};
      end
      OP_MV_X_S: begin
        src2 = keep_elem0(uop.vs2_data, uop.vs2_eew);
      end
      OP_MV_S_X: begin
        src1 = keep_elem0(VLEN'(uop.rs1_data), uop.vd_eew);
      end
      default: begin
        src1 = '0;
        src2 = '0;
      end
    endcase
  end

endmodule

// File: logic/other_op_decode.sv
`timescale 1ns/1ns

module other_op_decode
  import rvv_isa_pkg::*;
  import alu_uop_pkg::*;
(
  input  alu_uop_t  uop,
  input  logic      uop_valid,
  output op_class_e op_class,
  output logic      ext_signed,
  output logic      op_ok
);

  // operand valid flags match what the class needs
  logic ready;

  always_comb begin
    op_class   = OP_NONE;
    ext_signed = 1'b0;
    case (uop.funct3)
      OPIVV, OPIVX, OPIVI: begin
        if (uop.funct6 == VMERGE_VMV) begin
          op_class = uop.vm ? OP_MV_V : OP_MERGE;
        end else if (uop.funct6 == VSMUL_VMVNRR && uop.funct3 == OPIVI) begin
          op_class = OP_MV_NRR;
        end
      end
      OPMVV: begin
        if (uop.funct6 == VXUNARY0) begin
          case (uop.vs1)
            VZEXT_VF2: op_class = OP_EXT_VF2;
            VZEXT_VF4: op_class = OP_EXT_VF4;
            VSEXT_VF2: begin
              op_class   = OP_EXT_VF2;
              ext_signed = 1'b1;
            end
            VSEXT_VF4: begin
              op_class   = OP_EXT_VF4;
              ext_signed = 1'b1;
            end
            default: op_class = OP_NONE;
          endcase
        end else if (uop.funct6 == VWXUNARY0 && uop.vs1 == VMV_X_S) begin
          op_class = OP_MV_X_S;
        end
      end
      OPMVX: begin
        if (uop.funct6 == VWXUNARY0) begin
          op_class = OP_MV_S_X;
        end
      end
      default: op_class = OP_NONE;
    endcase
  end

  always_comb begin
    case (op_class)
      // vector form reads vs1, scalar and immediate forms read rs1
      OP_MV_V, OP_MERGE:
        ready = (uop.funct3 == OPIVV ? uop.vs1_data_valid : uop.rs1_data_valid) &&
                (uop.vm || (uop.vs2_data_valid && uop.v0_data_valid));
      OP_MV_NRR, OP_MV_X_S:
        ready = uop.vm && uop.vs2_data_valid;
      OP_EXT_VF2:
        ready = !uop.vs1_data_valid && uop.vs2_data_valid &&
                (uop.vs2_eew == EEW8 || uop.vs2_eew == EEW16);
      OP_EXT_VF4:
        ready = !uop.vs1_data_valid && uop.vs2_data_valid && uop.vs2_eew == EEW8;
      OP_MV_S_X:
        ready = uop.vm && uop.rs1_data_valid;
      default:
        ready = 1'b0;
    endcase
  end

  assign op_ok = uop_valid && ready;

endmodule

// File: logic/alu_uop_pkg.sv
package alu_uop_pkg;

  localparam int VLEN                = 128;
  localparam int XLEN                = 32;
  localparam int VLENB               = VLEN / 8;
  localparam int ROB_DEPTH_WIDTH     = 3;
  localparam int UOP_INDEX_WIDTH     = 3;
  localparam int REGFILE_INDEX_WIDTH = 5;

  // one ALU uop with its operands already read
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0]     rob_entry;
    logic [5:0]                     funct6;
    rvv_isa_pkg::funct3_e           funct3;
    logic                           vm;
    rvv_isa_pkg::eew_e              vd_eew;
    rvv_isa_pkg::eew_e              vs2_eew;
    logic [REGFILE_INDEX_WIDTH-1:0] vs1;
    logic [UOP_INDEX_WIDTH-1:0]     uop_index;
    logic [VLEN-1:0]                v0_data;
    logic                           v0_data_valid;
    logic [VLEN-1:0]                vs1_data;
    logic                           vs1_data_valid;
    logic [VLEN-1:0]                vs2_data;
    logic                           vs2_data_valid;
    logic [XLEN-1:0]                rs1_data;
    logic                           rs1_data_valid;
  } alu_uop_t;

  // write-back record toward the ROB
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
    logic                       w_valid;
  } rob_result_t;

  typedef enum logic [2:0] {
    OP_NONE    = 3'd0,
    OP_MV_V    = 3'd1,
    OP_MERGE   = 3'd2,
    OP_MV_NRR  = 3'd3,
    OP_EXT_VF2 = 3'd4,
    OP_EXT_VF4 = 3'd5,
    OP_MV_X_S  = 3'd6,
    OP_MV_S_X  = 3'd7
  } op_class_e;

endpackage

// File: logic/rvv_isa_pkg.sv
package rvv_isa_pkg;

  // element sizes in bits
  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;

  // element width as carried in the uop
  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // major opcode category, funct3 of OP-V
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  // funct6, arithmetic view only
  localparam logic [5:0] VMERGE_VMV   = 6'b010111;
  localparam logic [5:0] VSMUL_VMVNRR = 6'b100111;
  localparam logic [5:0] VXUNARY0     = 6'b010010;
  localparam logic [5:0] VWXUNARY0    = 6'b010000;

  // vs1 field used as sub-opcode
  localparam logic [4:0] VMV_X_S   = 5'b00000;
  localparam logic [4:0] VZEXT_VF4 = 5'b00100;
  localparam logic [4:0] VSEXT_VF4 = 5'b00101;
  localparam logic [4:0] VZEXT_VF2 = 5'b00110;
  localparam logic [4:0] VSEXT_VF2 = 5'b00111;

endpackage
